// File: common/systolic_pkg.sv
package systolic_pkg;

    // raw control bits as they arrive from the sequencer
    typedef struct packed {
        logic stat_bit;
        logic out_select;
        logic op2_select;
    } pe_ctl_t;

    // array phase after decode
    // load shifts weights down, matmul streams operands and sums
    typedef enum logic [1:0] {
        phase_hold   = 2'd0,
        phase_load   = 2'd1,
        phase_matmul = 2'd2
    } pe_phase_t;

    // stop-the-world self-test sequencer
    typedef enum logic [1:0] {
        stw_arm  = 2'd0,
        stw_idle = 2'd1,
        stw_run  = 2'd2
    } stw_state_t;

    // known-answer multiply-add
    // op1 * op2 + add must give expected
    localparam int stw_mult_op1 = 3;
    localparam int stw_mult_op2 = 5;
    localparam int stw_add_op   = 7;
    localparam int stw_expected = 22;

    // default array shape
    localparam int default_rows   = 4;
    localparam int default_cols   = 4;
    localparam int default_word_w = 16;

endpackage

// File: rtl/array_ctl_decode.sv
`timescale 1ns/1ps

module array_ctl_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  systolic_pkg::pe_ctl_t ctl,
    input  logic                  stw_en,
    output systolic_pkg::pe_phase_t phase,
    output logic                  stw_start
);

    systolic_pkg::stw_state_t stw_state;

    // phase decode, purely combinational
    always_comb begin
        if (ctl.op2_select && !ctl.out_select) begin
            phase = systolic_pkg::phase_load;
        end else if (ctl.out_select && !ctl.op2_select && ctl.stat_bit) begin
            phase = systolic_pkg::phase_matmul;
        end else begin
            phase = systolic_pkg::phase_hold;
        end
    end

    // arm once after reset, then accept one request per idle visit
    always_ff @(posedge clk) begin
        if (rst) begin
            stw_state <= systolic_pkg::stw_arm;
            stw_start <= 1'b0;
        end else begin
            stw_start <= 1'b0;
            case (stw_state)
                systolic_pkg::stw_arm: begin
                    stw_state <= systolic_pkg::stw_idle;
                end
                systolic_pkg::stw_idle: begin
                    if (stw_en) begin
                        stw_start <= 1'b1;
                        stw_state <= systolic_pkg::stw_run;
                    end
                end
                systolic_pkg::stw_run: begin
                    // start pulse drops here
                    stw_state <= systolic_pkg::stw_idle;
                end
                default: begin
                    stw_state <= systolic_pkg::stw_arm;
                end
            endcase
        end
    end

endmodule

// File: array/mac_pe.sv
`timescale 1ns/1ps

module mac_pe #(
    parameter int WORD_W = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  systolic_pkg::pe_phase_t  phase,
    input  logic                     stw_start,
    input  logic signed [WORD_W-1:0] left_in,
    input  logic signed [WORD_W-1:0] top_in,
    output logic signed [WORD_W-1:0] right_out,
    output logic signed [WORD_W-1:0] bottom_out,
    output logic                     stw_flag,
    output logic                     stw_ok
);

    logic signed [WORD_W-1:0] weight;
    logic signed [WORD_W-1:0] mac_sum;
    logic signed [WORD_W-1:0] stw_sum;

    // signed multiply-add, wraps to the word width
    function automatic logic signed [WORD_W-1:0] mac_op(
        input logic signed [WORD_W-1:0] a,
        input logic signed [WORD_W-1:0] b,
        input logic signed [WORD_W-1:0] c
    );
        logic signed [WORD_W-1:0] prod;
        prod = a * b;
        return prod + c;
    endfunction

    assign mac_sum = mac_op(left_in, weight, top_in);

    // known-answer operands from the package
    assign stw_sum = mac_op(WORD_W'(systolic_pkg::stw_mult_op1),
                            WORD_W'(systolic_pkg::stw_mult_op2),
                            WORD_W'(systolic_pkg::stw_add_op));

    // data path, frozen by stall and by the hold phase
    always_ff @(posedge clk) begin
        if (rst) begin
            weight     <= '0;
            right_out  <= '0;
            bottom_out <= '0;
        end else if (!stall) begin
            case (phase)
                systolic_pkg::phase_load: begin
                    weight     <= top_in;
                    bottom_out <= top_in;
                    right_out  <= left_in;
                end
                systolic_pkg::phase_matmul: begin
                    bottom_out <= mac_sum;
                    right_out  <= left_in;
                end
                default: begin
                end
            endcase
        end
    end

    // self-test result, independent of stall
    // flag is a one-cycle completion strobe, ok holds the last verdict
    always_ff @(posedge clk) begin
        if (rst) begin
            stw_flag <= 1'b0;
            stw_ok   <= 1'b0;
        end else begin
            stw_flag <= stw_start;
            if (stw_start) begin
                stw_ok <= (stw_sum == WORD_W'(systolic_pkg::stw_expected));
            end
        end
    end

endmodule

// File: array/mac_array.sv
`timescale 1ns/1ps

module mac_array #(
    parameter int ROWS   = 4,
    parameter int COLS   = 4,
    parameter int WORD_W = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall,
    input  systolic_pkg::pe_phase_t        phase,
    input  logic                           stw_start,
    input  logic [ROWS-1:0][WORD_W-1:0]    left_in,
    input  logic [COLS-1:0][WORD_W-1:0]    top_in,
    output logic [ROWS-1:0][WORD_W-1:0]    right_out,
    output logic [COLS-1:0][WORD_W-1:0]    bottom_out,
    output logic [ROWS*COLS-1:0]           stw_flag,
    output logic [ROWS*COLS-1:0]           stw_ok
);

    // hor[r][c] feeds the PE at (r,c) from the left
    // ver[r][c] feeds the PE at (r,c) from above
    wire [WORD_W-1:0] hor [ROWS][COLS+1];
    wire [WORD_W-1:0] ver [ROWS+1][COLS];

    genvar r, c;
    generate
        for (r = 0; r < ROWS; r++) begin : edge_row
            assign hor[r][0]    = left_in[r];
            assign right_out[r] = hor[r][COLS];
        end

        for (c = 0; c < COLS; c++) begin : edge_col
            assign ver[0][c]     = top_in[c];
            assign bottom_out[c] = ver[ROWS][c];
        end

        for (r = 0; r < ROWS; r++) begin : pe_row
            for (c = 0; c < COLS; c++) begin : pe_col
                // flags are column-major so a column's results sit together
                mac_pe #(
                    .WORD_W(WORD_W)
                ) u_pe (
                    .clk       (clk),
                    .rst       (rst),
                    .stall     (stall),
                    .phase     (phase),
                    .stw_start (stw_start),
                    .left_in   (hor[r][c]),
                    .top_in    (ver[r][c]),
                    .right_out (hor[r][c+1]),
                    .bottom_out(ver[r+1][c]),
                    .stw_flag  (stw_flag[c*ROWS + r]),
                    .stw_ok    (stw_ok[c*ROWS + r])
                );
            end
        end
    endgenerate

endmodule

// File: rtl/self_test_result.sv
`timescale 1ns/1ps

module self_test_result #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stw_start,
    input  logic [ROWS*COLS-1:0] stw_flag,
    input  logic [ROWS*COLS-1:0] stw_ok,
    output logic                 stw_done,
    output logic [ROWS*COLS-1:0] stw_pass
);

    // a new start wipes the previous verdict
    // done stays up until the next start
    always_ff @(posedge clk) begin
        if (rst) begin
            stw_done <= 1'b0;
            stw_pass <= '0;
        end else if (stw_start) begin
            stw_done <= 1'b0;
            stw_pass <= '0;
        end else if (&stw_flag) begin
            stw_done <= 1'b1;
            stw_pass <= stw_ok;
        end
    end

endmodule

// File: rtl/ws_systolic_top.sv
`timescale 1ns/1ps

module ws_systolic_top #(
    parameter int ROWS   = systolic_pkg::default_rows,
    parameter int COLS   = systolic_pkg::default_cols,
    parameter int WORD_W = systolic_pkg::default_word_w
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        stall,
    input  systolic_pkg::pe_ctl_t       ctl,
    input  logic                        stw_en,
    input  logic [ROWS-1:0][WORD_W-1:0] left_in,
    input  logic [COLS-1:0][WORD_W-1:0] top_in,
    output logic [COLS-1:0][WORD_W-1:0] bottom_out,
    output logic [ROWS-1:0][WORD_W-1:0] right_out,
    output logic                        stw_done,
    output logic [ROWS*COLS-1:0]        stw_pass
);

    systolic_pkg::pe_phase_t phase;
    logic                    stw_start;
    logic [ROWS*COLS-1:0]    stw_flag;
    logic [ROWS*COLS-1:0]    stw_ok;

    array_ctl_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .ctl      (ctl),
        .stw_en   (stw_en),
        .phase    (phase),
        .stw_start(stw_start)
    );

    mac_array #(
        .ROWS  (ROWS),
        .COLS  (COLS),
        .WORD_W(WORD_W)
    ) u_array (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .phase     (phase),
        .stw_start (stw_start),
        .left_in   (left_in),
        .top_in    (top_in),
        .right_out (right_out),
        .bottom_out(bottom_out),
        .stw_flag  (stw_flag),
        .stw_ok    (stw_ok)
    );

    self_test_result #(
        .ROWS(ROWS),
        .COLS(COLS)
    ) u_result (
        .clk      (clk),
        .rst      (rst),
        .stw_start(stw_start),
        .stw_flag (stw_flag),
        .stw_ok   (stw_ok),
        .stw_done (stw_done),
        .stw_pass (stw_pass)
    );

endmodule

// File: tests/ws_systolic_chk.sv
`timescale 1ns/1ps

module ws_systolic_chk (
    input logic                     clk,
    input logic                     rst,
    input logic                     stw_start,
    input logic                     stw_en,
    input systolic_pkg::stw_state_t stw_state
);

    int fail_count = 0;

    // start is a single-cycle pulse
    start_is_pulse: assert property (@(posedge clk) disable iff (rst)
        stw_start |=> !stw_start)
        else begin
            $error("stw_start stayed high for two cycles");
            fail_count++;
        end

    start_from_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(stw_start) |-> $past(stw_state) == systolic_pkg::stw_idle)
        else begin
            $error("stw_start rose outside the idle state");
            fail_count++;
        end

    // a request seen in idle must start the test on the next cycle
    accept_request: assert property (@(posedge clk) disable iff (rst)
        (stw_state == systolic_pkg::stw_idle && stw_en) |=> stw_start)
        else begin
            $error("stw_en in idle did not produce a start pulse");
            fail_count++;
        end

    start_low_after_reset: assert property (@(posedge clk) rst |=> !stw_start)
        else begin
            $error("stw_start high in the cycle after reset");
            fail_count++;
        end

endmodule

bind array_ctl_decode ws_systolic_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .stw_start(stw_start),
    .stw_en   (stw_en),
    .stw_state(stw_state)
);

// File: tests/ws_systolic_tb.sv
`timescale 1ns/1ps

module ws_systolic_tb;

    localparam int ROWS = 4;
    localparam int COLS = 4;
    localparam int W    = 16;

    logic                      clk;
    logic                      rst;
    logic                      stall;
    systolic_pkg::pe_ctl_t     ctl;
    logic                      stw_en;
    logic [ROWS-1:0][W-1:0]    left_in;
    logic [COLS-1:0][W-1:0]    top_in;
    logic [COLS-1:0][W-1:0]    bottom_out;
    logic [ROWS-1:0][W-1:0]    right_out;
    logic                      stw_done;
    logic [ROWS*COLS-1:0]      stw_pass;

    // reference copy of the PE grid
    logic signed [W-1:0] m_w   [ROWS][COLS];
    logic signed [W-1:0] m_rgt [ROWS][COLS];
    logic signed [W-1:0] m_bot [ROWS][COLS];
    logic [COLS-1:0][W-1:0] prev_bottom;
    logic [31:0] rng;
    int n_checks;
    int n_errors;

    ws_systolic_top #(.ROWS(ROWS), .COLS(COLS), .WORD_W(W)) dut (
        .clk(clk), .rst(rst), .stall(stall), .ctl(ctl), .stw_en(stw_en),
        .left_in(left_in), .top_in(top_in), .bottom_out(bottom_out),
        .right_out(right_out), .stw_done(stw_done), .stw_pass(stw_pass)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [W-1:0] rand_word();
        rng = xorshift32(rng);
        return rng[W-1:0];
    endfunction

    function automatic systolic_pkg::pe_ctl_t make_ctl(input logic s, input logic o,
                                                       input logic p);
        systolic_pkg::pe_ctl_t c;
        c.stat_bit   = s;
        c.out_select = o;
        c.op2_select = p;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [63:0] act,
                               input logic [63:0] exp);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, act, exp);
        end
    endtask

    // update the model from the sampled inputs and drive the next ones
    task automatic step(input logic rst_v, input logic stall_v,
                        input systolic_pkg::pe_ctl_t ctl_v, input logic en_v,
                        input logic [ROWS-1:0][W-1:0] left_v,
                        input logic [COLS-1:0][W-1:0] top_v);
        logic is_load;
        logic is_mm;
        logic held;
        logic signed [W-1:0] lft;
        logic signed [W-1:0] abv;
        logic signed [W-1:0] prod;
        logic [COLS-1:0][W-1:0] exp_b;
        logic [ROWS-1:0][W-1:0] exp_r;
        @(posedge clk);
        is_load = ctl.op2_select && !ctl.out_select;
        is_mm   = ctl.out_select && !ctl.op2_select && ctl.stat_bit;
        held    = stall && !rst;
        // walk backwards so neighbours still hold their old values
        for (int r = ROWS - 1; r >= 0; r--) begin
            for (int c = COLS - 1; c >= 0; c--) begin
                if (c == 0) lft = left_in[r];
                else lft = m_rgt[r][c-1];
                if (r == 0) abv = top_in[c];
                else abv = m_bot[r-1][c];
                if (rst) begin
                    m_w[r][c]   = '0;
                    m_rgt[r][c] = '0;
                    m_bot[r][c] = '0;
                end else if (!stall && is_load) begin
                    m_w[r][c]   = abv;
                    m_bot[r][c] = abv;
                    m_rgt[r][c] = lft;
                end else if (!stall && is_mm) begin
                    prod        = lft * m_w[r][c];
                    m_bot[r][c] = abv + prod;
                    m_rgt[r][c] = lft;
                end
            end
        end
        rst     <= rst_v;
        stall   <= stall_v;
        ctl     <= ctl_v;
        stw_en  <= en_v;
        left_in <= left_v;
        top_in  <= top_v;
        @(negedge clk);
        for (int c = 0; c < COLS; c++) exp_b[c] = m_bot[ROWS-1][c];
        for (int r = 0; r < ROWS; r++) exp_r[r] = m_rgt[r][COLS-1];
        check_value("bottom_out", bottom_out, exp_b);
        check_value("right_out", right_out, exp_r);
        if (held) check_value("bottom_out under stall", bottom_out, prev_bottom);
        prev_bottom = bottom_out;
    endtask

    // mostly matmul with some hold cycles and optional stall pulses
    task automatic traffic_cycle(input logic en, input logic use_stall);
        logic [ROWS-1:0][W-1:0] lv;
        logic [COLS-1:0][W-1:0] tv;
        systolic_pkg::pe_ctl_t c;
        logic st;
        for (int r = 0; r < ROWS; r++) lv[r] = rand_word();
        for (int i = 0; i < COLS; i++) tv[i] = rand_word();
        rng = xorshift32(rng);
        if (rng[2:0] == 3'd0) c = make_ctl(rng[8], 1'b1, rng[9]);
        else c = make_ctl(1'b1, 1'b1, 1'b0);
        st = use_stall && (rng[12:10] == 3'd0);
        step(1'b0, st, c, en, lv, tv);
    endtask

    task automatic run_self_test(input logic traffic);
        int n;
        logic seen_low;
        if (traffic) traffic_cycle(1'b1, 1'b0);
        else step(1'b0, 1'b0, '0, 1'b1, '0, '0);
        // this cycle holds the sampling edge
        if (traffic) traffic_cycle(1'b0, 1'b0);
        else step(1'b0, 1'b0, '0, 1'b0, '0, '0);
        // the cycle right after the sampling edge is the first one
        n = 1;
        seen_low = !stw_done;
        while (!(seen_low && stw_done) && n < 20) begin
            if (traffic) traffic_cycle(1'b0, 1'b0);
            else step(1'b0, 1'b0, '0, 1'b0, '0, '0);
            n++;
            if (!stw_done) seen_low = 1'b1;
        end
        if (n >= 20) begin
            n_errors++;
            $display("timeout: stw_done never rose after the self-test request");
        end else begin
            check_value("stw_done latency", n, 3);
            check_value("stw_pass", stw_pass, {ROWS*COLS{1'b1}});
            // done is sticky until the next start
            if (traffic) traffic_cycle(1'b0, 1'b0);
            else step(1'b0, 1'b0, '0, 1'b0, '0, '0);
            check_value("stw_done", stw_done, 1);
        end
    endtask

    initial begin
        logic [COLS-1:0][W-1:0] tv;
        rng = 32'd65716;
        n_checks = 0;
        n_errors = 0;
        prev_bottom = '0;
        rst = 1'b1;
        stall = 1'b0;
        ctl = '0;
        stw_en = 1'b0;
        left_in = '0;
        top_in = '0;
        repeat (15) step(1'b1, 1'b0, '0, 1'b0, '0, '0);
        step(1'b0, 1'b0, '0, 1'b0, '0, '0);
        check_value("stw_done", stw_done, 0);
        check_value("stw_pass", stw_pass, 0);
        repeat (2) step(1'b0, 1'b0, '0, 1'b0, '0, '0);
        run_self_test(1'b0);
        // shift one weight per column into every row
        for (int k = 0; k < ROWS; k++) begin
            for (int i = 0; i < COLS; i++) tv[i] = rand_word();
            step(1'b0, 1'b0, make_ctl(1'b0, 1'b0, 1'b1), 1'b0, '0, tv);
        end
        repeat (300) traffic_cycle(1'b0, 1'b0);
        repeat (200) traffic_cycle(1'b0, 1'b1);
        run_self_test(1'b1);
        repeat (20) traffic_cycle(1'b0, 1'b1);
        n_errors += dut.u_decode.u_chk.fail_count;
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: ws_systolic.f
common/systolic_pkg.sv
rtl/array_ctl_decode.sv
array/mac_pe.sv
array/mac_array.sv
rtl/self_test_result.sv
rtl/ws_systolic_top.sv
tests/ws_systolic_chk.sv
tests/ws_systolic_tb.sv
